//--- rtl/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// datapath and tag widths
`define EXEC_XLEN    32
`define EXEC_TAG_W   8

`define EXEC_Q_DEPTH 4

// one extra bit for sign extension in mul/div
`define EXEC_MD_W    33

`endif

//--- rtl/exec_pkg.sv
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]   word_t;
    typedef logic [`EXEC_TAG_W-1:0]  tag_t;
    typedef logic [`EXEC_MD_W-1:0]   md_word_t;
    typedef logic [2*`EXEC_MD_W-1:0] md_prod_t;

    typedef enum logic [3:0] {
        ALU_X, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_X, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_t;

    typedef enum logic [3:0] {
        MD_X, MD_MUL, MD_MULH, MD_MULHU, MD_MULHSU,
        MD_DIV, MD_DIVU, MD_REM, MD_REMU
    } md_op_t;

    typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_DONE} div_state_t;
    typedef enum logic [1:0] {MUL_IDLE, MUL_RUN, MUL_DONE} mul_state_t;

    typedef struct packed {
        alu_op_t alu_op;
        br_op_t  br_op;
        md_op_t  md_op;
        logic    jmp_pc_flg;  // jal
        logic    jmp_reg_flg; // jalr
    } exec_ctrl_t;

    typedef struct packed {
        tag_t       tag;
        word_t      pc;
        exec_ctrl_t ctrl;
        word_t      op1;
        word_t      op2;
        word_t      imm_b;
        word_t      imm_j;
    } exec_req_t;

    typedef struct packed {
        tag_t  tag;
        word_t pc;
        word_t result;
    } exec_res_t;

endpackage

`default_nettype wire

//--- rtl/int_alu.sv
`default_nettype none

module int_alu (
    input  exec_pkg::alu_op_t alu_op,
    input  exec_pkg::br_op_t  br_op,
    input  exec_pkg::word_t   op1,
    input  exec_pkg::word_t   op2,
    output exec_pkg::word_t   alu_out,
    output logic              branch_take
);

    logic [4:0] shamt;

    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op)
            exec_pkg::ALU_ADD:  alu_out = op1 + op2;
            exec_pkg::ALU_SUB:  alu_out = op1 - op2;
            exec_pkg::ALU_AND:  alu_out = op1 & op2;
            exec_pkg::ALU_OR:   alu_out = op1 | op2;
            exec_pkg::ALU_XOR:  alu_out = op1 ^ op2;
            exec_pkg::ALU_SLL:  alu_out = op1 << shamt;
            exec_pkg::ALU_SRL:  alu_out = op1 >> shamt;
            exec_pkg::ALU_SRA:  alu_out = $signed(op1) >>> shamt;
            exec_pkg::ALU_SLT: begin
                alu_out = {31'd0, $signed(op1) < $signed(op2)};
            end
            exec_pkg::ALU_SLTU: begin
                alu_out = {31'd0, op1 < op2};
            end
            default:            alu_out = '0;
        endcase
    end

    always_comb begin
        case (br_op)
            exec_pkg::BR_BEQ:  branch_take = (op1 == op2);
            exec_pkg::BR_BNE:  branch_take = (op1 != op2);
            exec_pkg::BR_BLT:  branch_take = ($signed(op1) < $signed(op2));
            exec_pkg::BR_BGE:  branch_take = ($signed(op1) >= $signed(op2));
            exec_pkg::BR_BLTU: branch_take = (op1 < op2);
            exec_pkg::BR_BGEU: branch_take = (op1 >= op2);
            default:           branch_take = 1'b0; // not a branch
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/serial_divider.sv
`default_nettype none

`include "exec_macros.svh"

module serial_divider (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               is_signed,
    input  exec_pkg::md_word_t dividend,
    input  exec_pkg::md_word_t divisor,
    output logic               ready,
    output logic               valid,
    output exec_pkg::md_word_t quotient,
    output exec_pkg::md_word_t remainder
);

    localparam int CNT_W = $clog2(`EXEC_MD_W);

    exec_pkg::div_state_t state;
    logic [CNT_W-1:0]     cnt;
    exec_pkg::md_word_t   quo;
    exec_pkg::md_word_t   rem;
    exec_pkg::md_word_t   dsor;
    exec_pkg::md_word_t   dvd_mag;
    exec_pkg::md_word_t   dsr_mag;
    logic                 neg_q;
    logic                 neg_r;
    logic                 dvd_neg;
    logic                 dsr_neg;
    logic [`EXEC_MD_W:0]  trial;
    logic [`EXEC_MD_W:0]  diff;

    assign dvd_neg = is_signed && dividend[`EXEC_MD_W-1];
    assign dsr_neg = is_signed && divisor[`EXEC_MD_W-1];
    assign dvd_mag = dvd_neg ? -dividend : dividend;
    assign dsr_mag = dsr_neg ? -divisor : divisor;
    assign trial   = {rem, quo[`EXEC_MD_W-1]}; // shift next dividend bit in
    assign diff    = trial - {1'b0, dsor};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= exec_pkg::DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::DIV_IDLE: begin
                    if (start) begin
                        // divide by zero needs no iterations
                        state <= (divisor == '0) ? exec_pkg::DIV_DONE : exec_pkg::DIV_RUN;
                        cnt   <= CNT_W'(`EXEC_MD_W - 1);
                    end
                end
                exec_pkg::DIV_RUN: begin
                    if (cnt == '0)
                        state <= exec_pkg::DIV_DONE;
                    cnt <= cnt - 1'b1;
                end
                default: state <= exec_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exec_pkg::DIV_IDLE && start) begin
            if (divisor == '0) begin
                quo   <= '1;
                rem   <= dividend;
                neg_q <= 1'b0;
                neg_r <= 1'b0;
            end else begin
                quo   <= dvd_mag;
                rem   <= '0;
                dsor  <= dsr_mag;
                neg_q <= dvd_neg ^ dsr_neg;
                neg_r <= dvd_neg; // remainder takes dividend sign
            end
        end else if (state == exec_pkg::DIV_RUN) begin
            if (trial >= {1'b0, dsor}) begin
                rem <= diff[`EXEC_MD_W-1:0];
                quo <= {quo[`EXEC_MD_W-2:0], 1'b1};
            end else begin
                rem <= trial[`EXEC_MD_W-1:0];
                quo <= {quo[`EXEC_MD_W-2:0], 1'b0};
            end
        end
    end

    assign ready     = (state == exec_pkg::DIV_IDLE);
    assign valid     = (state == exec_pkg::DIV_DONE);
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

//--- rtl/serial_multiplier.sv
`default_nettype none

`include "exec_macros.svh"

module serial_multiplier (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic               is_signed,
    input  exec_pkg::md_word_t multiplicand,
    input  exec_pkg::md_word_t multiplier,
    output logic               ready,
    output logic               valid,
    output exec_pkg::md_prod_t product
);

    localparam int CNT_W = $clog2(`EXEC_MD_W);

    exec_pkg::mul_state_t state;
    logic [CNT_W-1:0]     cnt;
    exec_pkg::md_word_t   mcand;
    exec_pkg::md_prod_t   prod;  // {partial sum, remaining multiplier bits}
    logic                 neg;
    logic                 a_neg;
    logic                 b_neg;
    logic [`EXEC_MD_W:0]  sum;

    assign a_neg = is_signed && multiplicand[`EXEC_MD_W-1];
    assign b_neg = is_signed && multiplier[`EXEC_MD_W-1];
    assign sum   = {1'b0, prod[2*`EXEC_MD_W-1:`EXEC_MD_W]}
                 + (prod[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= exec_pkg::MUL_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                exec_pkg::MUL_IDLE: begin
                    if (start) begin
                        state <= exec_pkg::MUL_RUN;
                        cnt   <= CNT_W'(`EXEC_MD_W - 1);
                    end
                end
                exec_pkg::MUL_RUN: begin
                    if (cnt == '0)
                        state <= exec_pkg::MUL_DONE;
                    cnt <= cnt - 1'b1;
                end
                default: state <= exec_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == exec_pkg::MUL_IDLE && start) begin
            mcand <= a_neg ? -multiplicand : multiplicand;
            prod  <= {{`EXEC_MD_W{1'b0}}, b_neg ? -multiplier : multiplier};
            neg   <= a_neg ^ b_neg;
        end else if (state == exec_pkg::MUL_RUN) begin
            prod <= {sum, prod[`EXEC_MD_W-1:1]};
        end
    end

    assign ready   = (state == exec_pkg::MUL_IDLE);
    assign valid   = (state == exec_pkg::MUL_DONE);
    assign product = neg ? -prod : prod;

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`default_nettype none

`include "exec_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  exec_pkg::exec_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                pipeline_flush,
    input  logic                q_full,
    output exec_pkg::exec_res_t res,
    output logic                res_push,
    output logic                branch_taken,
    output exec_pkg::word_t     branch_target
);

    exec_pkg::md_op_t   md_op;
    exec_pkg::word_t    alu_out;
    exec_pkg::word_t    md_sel;
    exec_pkg::word_t    saved_result;
    exec_pkg::tag_t     saved_tag;
    exec_pkg::md_word_t div_dvd, div_dsr, div_q, div_r;
    exec_pkg::md_word_t mul_a, mul_b;
    exec_pkg::md_prod_t mul_p;
    logic is_div, is_mul, is_md;
    logic div_signed, mul_signed;
    logic div_start, div_ready, div_valid;
    logic mul_start, mul_ready, mul_valid;
    logic started, calculated, done_hit, stall, unit_valid;
    logic alu_branch;

    assign md_op  = req.ctrl.md_op;
    assign is_div = md_op inside {exec_pkg::MD_DIV, exec_pkg::MD_DIVU,
                                  exec_pkg::MD_REM, exec_pkg::MD_REMU};
    assign is_mul = md_op inside {exec_pkg::MD_MUL, exec_pkg::MD_MULH,
                                  exec_pkg::MD_MULHU, exec_pkg::MD_MULHSU};
    assign is_md  = is_div || is_mul;

    assign div_signed = md_op inside {exec_pkg::MD_DIV, exec_pkg::MD_REM};
    assign mul_signed = md_op inside {exec_pkg::MD_MUL, exec_pkg::MD_MULH, exec_pkg::MD_MULHSU};
    assign div_dvd = {div_signed && req.op1[`EXEC_XLEN-1], req.op1};
    assign div_dsr = {div_signed && req.op2[`EXEC_XLEN-1], req.op2};
    assign mul_a   = {mul_signed && req.op1[`EXEC_XLEN-1], req.op1};
    assign mul_b   = {mul_signed && md_op != exec_pkg::MD_MULHSU && req.op2[`EXEC_XLEN-1],
                      req.op2}; // rs2 unsigned for mulhsu

    // result already computed for this very request
    assign done_hit   = calculated && saved_tag == req.tag;
    assign stall      = req_valid && is_md && !done_hit;
    assign div_start  = req_valid && is_div && !started && !done_hit && div_ready
                        && !pipeline_flush;
    assign mul_start  = req_valid && is_mul && !started && !done_hit && mul_ready
                        && !pipeline_flush;
    assign unit_valid = is_div ? div_valid : mul_valid;

    int_alu u_alu (
        .alu_op      (req.ctrl.alu_op),
        .br_op       (req.ctrl.br_op),
        .op1         (req.op1),
        .op2         (req.op2),
        .alu_out     (alu_out),
        .branch_take (alu_branch)
    );

    serial_divider u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (div_start),
        .is_signed (div_signed),
        .dividend  (div_dvd),
        .divisor   (div_dsr),
        .ready     (div_ready),
        .valid     (div_valid),
        .quotient  (div_q),
        .remainder (div_r)
    );

    serial_multiplier u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (mul_start),
        .is_signed    (mul_signed),
        .multiplicand (mul_a),
        .multiplier   (mul_b),
        .ready        (mul_ready),
        .valid        (mul_valid),
        .product      (mul_p)
    );

    always_comb begin
        case (md_op)
            exec_pkg::MD_DIV, exec_pkg::MD_DIVU: md_sel = div_q[`EXEC_XLEN-1:0];
            exec_pkg::MD_REM, exec_pkg::MD_REMU: md_sel = div_r[`EXEC_XLEN-1:0];
            exec_pkg::MD_MUL:                    md_sel = mul_p[`EXEC_XLEN-1:0];
            default:                             md_sel = mul_p[2*`EXEC_XLEN-1:`EXEC_XLEN];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started    <= 1'b0;
            calculated <= 1'b0;
        end else if (pipeline_flush || !req_valid || !is_md || res_push) begin
            started    <= 1'b0; // abandon, unit drains on its own
            calculated <= 1'b0;
        end else if (started && unit_valid) begin
            started    <= 1'b0;
            calculated <= 1'b1;
        end else if (div_start || mul_start) begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (started && unit_valid) begin
            saved_result <= md_sel;
            saved_tag    <= req.tag;
        end
    end

    assign req_ready  = !stall && !q_full && !pipeline_flush;
    assign res_push   = req_valid && req_ready;
    assign res.tag    = req.tag;
    assign res.pc     = req.pc;
    assign res.result = is_md ? saved_result : alu_out;

    assign branch_taken  = req_valid &&
                           (req.ctrl.jmp_pc_flg || req.ctrl.jmp_reg_flg || alu_branch);
    assign branch_target = req.ctrl.jmp_pc_flg  ? req.pc + req.imm_j :
                           req.ctrl.jmp_reg_flg ? req.op1 + req.op2 :
                           req.pc + req.imm_b;

endmodule

`default_nettype wire

//--- rtl/exec_result_queue.sv
`default_nettype none

`include "exec_macros.svh"

module exec_result_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  exec_pkg::exec_res_t push_data,
    output logic                full,
    output exec_pkg::exec_res_t res,
    output logic                res_valid,
    input  logic                res_ready
);

    localparam int PTR_W = $clog2(`EXEC_Q_DEPTH);
    localparam int CNT_W = $clog2(`EXEC_Q_DEPTH + 1);

    exec_pkg::exec_res_t mem [`EXEC_Q_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                do_push;
    logic                do_pop;

    assign full      = (count == CNT_W'(`EXEC_Q_DEPTH));
    assign res_valid = (count != '0);
    assign res       = mem[rd_ptr];
    assign do_push   = push && !full;
    assign do_pop    = res_valid && res_ready;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(`EXEC_Q_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(`EXEC_Q_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1; // simultaneous push/pop keeps count
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_top.sv
`default_nettype none

module exec_top (
    input  logic                clk,
    input  logic                rst_n,
    input  exec_pkg::exec_req_t req,
    input  logic                req_valid,
    output logic                req_ready,
    input  logic                pipeline_flush,
    output logic                branch_taken,
    output exec_pkg::word_t     branch_target,
    output exec_pkg::exec_res_t res,
    output logic                res_valid,
    input  logic                res_ready
);

    exec_pkg::exec_res_t stage_res;
    logic                res_push;
    logic                q_full;

    execute_stage u_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .pipeline_flush (pipeline_flush),
        .q_full         (q_full),
        .res            (stage_res),
        .res_push       (res_push),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target)
    );

    exec_result_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (res_push),
        .push_data (stage_res),
        .full      (q_full),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

endmodule

`default_nettype wire

//--- sim/exec_tb.sv
`default_nettype none

`include "exec_macros.svh"

module exec_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        exec_pkg::alu_op_t alu_op;
        exec_pkg::br_op_t  br_op;
        exec_pkg::md_op_t  md_op;
        logic              jmp_pc;
        logic              jmp_reg;
        logic              flush;   // flush while the op is still computing
        exec_pkg::word_t   op1;
        exec_pkg::word_t   op2;
        exec_pkg::word_t   pc;
        exec_pkg::word_t   imm_b;
        exec_pkg::word_t   imm_j;
    } entry_t;

    logic                clk;
    logic                rst_n;
    exec_pkg::exec_req_t req;
    logic                req_valid;
    logic                req_ready;
    logic                pipeline_flush;
    logic                branch_taken;
    exec_pkg::word_t     branch_target;
    exec_pkg::exec_res_t res;
    logic                res_valid;
    logic                res_ready;

    entry_t              table_q[$];
    exec_pkg::exec_res_t exp_q[$];
    exec_pkg::exec_res_t cur_exp;
    logic                cur_taken;
    exec_pkg::word_t     cur_target;
    exec_pkg::tag_t      tag_cnt = '0;
    logic [31:0]         rnd_state = 32'he5c5;
    logic                table_ready = 1'b0;

    exec_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .pipeline_flush (pipeline_flush),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .res            (res),
        .res_valid      (res_valid),
        .res_ready      (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rnd_state = rnd_state ^ (rnd_state << 13);
        rnd_state = rnd_state ^ (rnd_state >> 17);
        rnd_state = rnd_state ^ (rnd_state << 5);
        return rnd_state;
    endfunction

    function automatic exec_pkg::word_t ref_alu(exec_pkg::alu_op_t op, exec_pkg::word_t a,
                                                exec_pkg::word_t b);
        logic [63:0] wide;
        case (op)
            exec_pkg::ALU_ADD:  wide = {32'd0, a} + {32'd0, b};
            exec_pkg::ALU_SUB:  wide = {32'd0, a} - {32'd0, b};
            exec_pkg::ALU_AND:  wide = {32'd0, a & b};
            exec_pkg::ALU_OR:   wide = {32'd0, a | b};
            exec_pkg::ALU_XOR:  wide = {32'd0, a ^ b};
            exec_pkg::ALU_SLL:  wide = {32'd0, a} << b[4:0];
            exec_pkg::ALU_SRL:  wide = {32'd0, a} >> b[4:0];
            exec_pkg::ALU_SRA:  wide = {{32{a[31]}}, a} >> b[4:0]; // sign bits shift in
            exec_pkg::ALU_SLT:  wide = {63'd0, $signed(a) < $signed(b)};
            exec_pkg::ALU_SLTU: wide = {63'd0, a < b};
            default:            wide = '0;
        endcase
        return wide[31:0];
    endfunction

    function automatic logic ref_cond(exec_pkg::br_op_t op, exec_pkg::word_t a,
                                      exec_pkg::word_t b);
        logic signed [32:0] sa;
        logic signed [32:0] sb;
        sa = {a[31], a};
        sb = {b[31], b};
        case (op)
            exec_pkg::BR_BEQ:  return a == b;
            exec_pkg::BR_BNE:  return a != b;
            exec_pkg::BR_BLT:  return sa < sb;
            exec_pkg::BR_BGE:  return !(sa < sb);
            exec_pkg::BR_BLTU: return a < b;
            exec_pkg::BR_BGEU: return !(a < b);
            default:           return 1'b0;
        endcase
    endfunction

    function automatic exec_pkg::word_t ref_md(exec_pkg::md_op_t op, exec_pkg::word_t a,
                                               exec_pkg::word_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] p;
        logic [63:0]        ua;
        logic [63:0]        ub;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'd0, a};
        ub = {32'd0, b};
        case (op)
            exec_pkg::MD_MUL:    p = sa * sb;
            exec_pkg::MD_MULH:   p = (sa * sb) >>> 32;
            exec_pkg::MD_MULHU:  p = (ua * ub) >> 32;
            exec_pkg::MD_MULHSU: p = (sa * $signed(ub)) >>> 32;
            exec_pkg::MD_DIV: begin
                if (b == '0)
                    p = '1;
                else if (a == 32'h8000_0000 && b == '1)
                    p = {32'd0, a}; // overflow keeps the dividend
                else
                    p = sa / sb;
            end
            exec_pkg::MD_REM: begin
                if (b == '0)
                    p = {32'd0, a};
                else if (a == 32'h8000_0000 && b == '1)
                    p = '0;
                else
                    p = sa % sb;
            end
            exec_pkg::MD_DIVU:   p = (b == '0) ? '1 : ua / ub;
            exec_pkg::MD_REMU:   p = (b == '0) ? ua : ua % ub;
            default:             p = '0;
        endcase
        return p[31:0];
    endfunction

    task automatic report_error(string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_res(exec_pkg::exec_res_t got, exec_pkg::exec_res_t exp);
        if (got !== exp)
            report_error($sformatf("result tag %0h pc %h data %h, expected tag %0h pc %h data %h",
                                   got.tag, got.pc, got.result, exp.tag, exp.pc, exp.result));
    endtask

    task automatic check_branch(logic got_taken, logic exp_taken, exec_pkg::word_t got_tgt,
                                exec_pkg::word_t exp_tgt);
        if (got_taken !== exp_taken || got_tgt !== exp_tgt)
            report_error($sformatf("branch taken %b target %h, expected taken %b target %h",
                                   got_taken, got_tgt, exp_taken, exp_tgt));
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    function automatic entry_t mk(exec_pkg::alu_op_t alu, exec_pkg::br_op_t br,
                                  exec_pkg::md_op_t md, logic jpc, logic jreg, logic flush,
                                  exec_pkg::word_t a, exec_pkg::word_t b);
        entry_t      e;
        logic [31:0] r;
        e.alu_op  = alu;
        e.br_op   = br;
        e.md_op   = md;
        e.jmp_pc  = jpc;
        e.jmp_reg = jreg;
        e.flush   = flush;
        e.op1     = a;
        e.op2     = b;
        e.pc      = 32'h0000_1000 + (next_rand() & 32'h0000_fffc);
        r         = next_rand();
        e.imm_b   = r[0] ? 32'hffff_fff0 : 32'h0000_0040;
        e.imm_j   = {{12{r[19]}}, r[19:1], 1'b0};
        return e;
    endfunction

    task automatic add_alu(exec_pkg::alu_op_t op, exec_pkg::word_t a, exec_pkg::word_t b);
        table_q.push_back(mk(op, exec_pkg::BR_X, exec_pkg::MD_X, 1'b0, 1'b0, 1'b0, a, b));
    endtask

    task automatic add_md(exec_pkg::md_op_t op, logic flush, exec_pkg::word_t a,
                          exec_pkg::word_t b);
        table_q.push_back(mk(exec_pkg::ALU_X, exec_pkg::BR_X, op, 1'b0, 1'b0, flush, a, b));
    endtask

    task automatic build_table();
        exec_pkg::md_op_t mop;
        add_alu(exec_pkg::ALU_ADD, 32'h7fff_ffff, 32'h1);
        add_alu(exec_pkg::ALU_SUB, 32'h0, 32'h1);
        add_alu(exec_pkg::ALU_AND, 32'hf0f0_f0f0, 32'hff00_ff00);
        add_alu(exec_pkg::ALU_OR, 32'h0f0f_0000, 32'h0000_f0f0);
        add_alu(exec_pkg::ALU_XOR, 32'hffff_ffff, 32'h1234_5678);
        add_alu(exec_pkg::ALU_SLL, 32'h1, 32'd31);
        add_alu(exec_pkg::ALU_SRL, 32'h8000_0000, 32'd63); // only shamt[4:0] counts
        add_alu(exec_pkg::ALU_SRA, 32'h8000_0000, 32'd4);
        add_alu(exec_pkg::ALU_SLT, 32'hffff_ffff, 32'h1);
        add_alu(exec_pkg::ALU_SLTU, 32'hffff_ffff, 32'h1);
        add_alu(exec_pkg::ALU_X, 32'h5, 32'h6);
        for (int i = 0; i < 20; i++)
            add_alu(exec_pkg::alu_op_t'(1 + i % 10), next_rand(), next_rand());
        for (int i = 1; i <= 6; i++) begin
            table_q.push_back(mk(exec_pkg::ALU_X, exec_pkg::br_op_t'(i), exec_pkg::MD_X,
                                 1'b0, 1'b0, 1'b0, 32'h8000_0000, 32'h8000_0000));
            table_q.push_back(mk(exec_pkg::ALU_X, exec_pkg::br_op_t'(i), exec_pkg::MD_X,
                                 1'b0, 1'b0, 1'b0, next_rand(), next_rand()));
        end
        table_q.push_back(mk(exec_pkg::ALU_ADD, exec_pkg::BR_X, exec_pkg::MD_X,
                             1'b1, 1'b0, 1'b0, 32'h2000, 32'h4)); // jal
        table_q.push_back(mk(exec_pkg::ALU_ADD, exec_pkg::BR_X, exec_pkg::MD_X,
                             1'b0, 1'b1, 1'b0, next_rand(), 32'hffff_fffc)); // jalr
        for (int i = 1; i <= 4; i++) begin
            mop = exec_pkg::md_op_t'(i);
            add_md(mop, 1'b0, 32'h8000_0000, 32'h8000_0000);
            add_md(mop, 1'b0, 32'hffff_ffff, 32'h7fff_ffff);
            add_md(mop, 1'b0, 32'h8000_0000, 32'hffff_ffff);
            add_md(mop, 1'b0, next_rand(), next_rand());
        end
        for (int i = 5; i <= 8; i++) begin
            mop = exec_pkg::md_op_t'(i);
            add_md(mop, 1'b0, next_rand(), 32'h0);
            add_md(mop, 1'b0, 32'h8000_0000, 32'hffff_ffff);
            add_md(mop, 1'b0, 32'hffff_fff9, 32'h2);
            add_md(mop, 1'b0, next_rand(), next_rand() >> (next_rand() & 32'h1f));
        end
        add_md(exec_pkg::MD_DIV, 1'b1, 32'h8765_4321, 32'h0000_0123);
        add_md(exec_pkg::MD_REMU, 1'b1, next_rand(), 32'h0001_0007);
    endtask

    task automatic present_req(entry_t e);
        @(posedge clk);
        #1;
        req.tag              = tag_cnt;
        req.pc               = e.pc;
        req.ctrl.alu_op      = e.alu_op;
        req.ctrl.br_op       = e.br_op;
        req.ctrl.md_op       = e.md_op;
        req.ctrl.jmp_pc_flg  = e.jmp_pc;
        req.ctrl.jmp_reg_flg = e.jmp_reg;
        req.op1              = e.op1;
        req.op2              = e.op2;
        req.imm_b            = e.imm_b;
        req.imm_j            = e.imm_j;
        req_valid            = 1'b1;
        cur_exp.tag          = tag_cnt;
        cur_exp.pc           = e.pc;
        cur_exp.result       = (e.md_op != exec_pkg::MD_X) ? ref_md(e.md_op, e.op1, e.op2)
                                                           : ref_alu(e.alu_op, e.op1, e.op2);
        cur_taken            = e.jmp_pc || e.jmp_reg || ref_cond(e.br_op, e.op1, e.op2);
        cur_target           = e.jmp_pc ? e.pc + e.imm_j :
                               e.jmp_reg ? e.op1 + e.op2 : e.pc + e.imm_b;
        tag_cnt++;
    endtask

    task automatic await_accept();
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (req_ready) begin
                check_branch(branch_taken, cur_taken, branch_target, cur_target);
                exp_q.push_back(cur_exp);
                accepted = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic send(entry_t e);
        present_req(e);
        if (e.flush) begin
            repeat (10) @(posedge clk);
            #1;
            pipeline_flush = 1'b1;
            // held past the normal end of the divide
            repeat (2 * `EXEC_MD_W) begin
                @(negedge clk);
                check_flag(req_ready, 1'b0, "req_ready during flush");
            end
            @(posedge clk);
            #1;
            pipeline_flush = 1'b0; // same request stays on the port
        end
        await_accept();
    endtask

    task automatic back_pressure();
        while (exp_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
        res_ready = 1'b0;
        repeat (`EXEC_Q_DEPTH)
            send(mk(exec_pkg::ALU_XOR, exec_pkg::BR_X, exec_pkg::MD_X, 1'b0, 1'b0, 1'b0,
                    next_rand(), next_rand()));
        present_req(mk(exec_pkg::ALU_ADD, exec_pkg::BR_X, exec_pkg::MD_X, 1'b0, 1'b0, 1'b0,
                       next_rand(), next_rand()));
        repeat (3) begin
            @(negedge clk);
            check_flag(req_ready, 1'b0, "req_ready with a full queue");
        end
        check_flag(res_valid, 1'b1, "res_valid with a full queue");
        @(posedge clk);
        #1;
        res_ready = 1'b1;
        await_accept();
    endtask

    // checks every popped result in order
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n && res_valid && res_ready) begin
                if (exp_q.size() == 0)
                    report_error("result popped while none was expected");
                else
                    check_res(res, exp_q.pop_front());
            end
        end
    end

    initial begin
        longint limit;
        wait (table_ready);
        limit = longint'(table_q.size() + `EXEC_Q_DEPTH + 1) * 60 * 8;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst_n          = 1'b0;
        req            = '0;
        req_valid      = 1'b0;
        pipeline_flush = 1'b0;
        res_ready      = 1'b1;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(res_valid, 1'b0, "res_valid after reset");
        foreach (table_q[i])
            send(table_q[i]);
        back_pressure();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/serial_divider.sv
rtl/serial_multiplier.sv
rtl/execute_stage.sv
rtl/exec_result_queue.sv
rtl/exec_top.sv
sim/exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module exec_tb \
    -o exec_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/exec_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
